// ==== bench/vga_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_tb;
   import vga_pkg::*;

   // --------------------
   // tiny raster
   // --------------------
   localparam int ACTIVE_H = 32;
   localparam int ACTIVE_V = 6;
   localparam int HFP      = 2;
   localparam int H_PULSE  = 3;
   localparam int HBP      = 4;
   localparam int VFP      = 1;
   localparam int V_PULSE  = 2;
   localparam int VBP      = 2;

   // 41 cycles per line and 451 per frame
   localparam int LINE_CYCLES    = HFP + H_PULSE + HBP + ACTIVE_H;
   localparam int FRAME_LINES    = VFP + V_PULSE + VBP + ACTIVE_V;
   localparam int FRAME_CYCLES   = LINE_CYCLES * FRAME_LINES;
   localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 200;
   localparam int SEED           = 19483;

   localparam pixel_t WHITE = pixel_t'(3'b111);
   localparam pixel_t BLACK = pixel_t'(3'b000);

   logic       clk_36MHz = 1'b0;
   logic       reset;
   pattern_e   pattern;
   pixel_t     rgb;
   video_out_t video;
   logic [9:0] x;
   logic [9:0] y;
   logic       vsync;

   // run lengths and edge history of the video port
   int hs_run;
   int vs_run;
   int de_run;
   int de_lines;
   int hs_lines;
   logic prev_hsync;
   logic prev_vsync;
   logic prev_de;
   logic frame_seen;

   // result counters
   int pass_count   = 0;
   int error_count  = 0;
   int pix_checked  = 0;
   int pix_errors   = 0;
   int geom_errors  = 0;
   int coord_errors = 0;
   int reset_errors = 0;
   int cycle_count  = 0;

   assign vsync = video.vsync;

   vga_top #(
      .ACTIVE_H (ACTIVE_H),
      .ACTIVE_V (ACTIVE_V),
      .HFP      (HFP),
      .H_PULSE  (H_PULSE),
      .HBP      (HBP),
      .VFP      (VFP),
      .V_PULSE  (V_PULSE),
      .VBP      (VBP)
   ) i_dut (
      .clk_36MHz (clk_36MHz),
      .reset     (reset),
      .pattern   (pattern),
      .rgb       (rgb),
      .video     (video),
      .x         (x),
      .y         (y)
   );

   // 100 ns period
   always #50 clk_36MHz = ~clk_36MHz;

   // --------------------
   // reference and checks
   // --------------------
   function automatic pixel_t pattern_ref(input pattern_e pat, input pixel_t colour,
                                          input int px, input int py);
      pixel_t result;
      int     bar;
      // eight bars with white first
      bar = px / (ACTIVE_H / 8);
      case (pat)
         PAT_BARS:    result = pixel_t'(3'(7 - bar));
         PAT_CHECKER: result = (((px >> CHECKER_SHIFT) ^ (py >> CHECKER_SHIFT)) & 1) != 0 ?
                               WHITE : BLACK;
         PAT_SOLID:   result = colour;
         PAT_BORDER:  result = (px == 0 || px == ACTIVE_H - 1 || py == 0 || py == ACTIVE_V - 1) ?
                               WHITE : BLACK;
         default:     result = BLACK;
      endcase
      return result;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual, inout int errors);
      if (expected === actual)
         pass_count++;
      else
      begin
         error_count++;
         errors++;
         $display("ERROR %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
      end
   endtask

   // idle output state around reset
   task automatic check_idle_outputs;
      check_value("video.hsync", 1, {31'd0, video.hsync}, reset_errors);
      check_value("video.vsync", 1, {31'd0, video.vsync}, reset_errors);
      check_value("video.de", 0, {31'd0, video.de}, reset_errors);
      check_value("video.pixel", 0, {29'd0, video.pixel}, reset_errors);
      check_value("x", 0, {22'd0, x}, reset_errors);
      check_value("y", 0, {22'd0, y}, reset_errors);
   endtask

   // new setting 10 ns after the edge that dropped vsync
   task automatic apply_setting(input pattern_e pat, input pixel_t colour);
      #10;
      pattern = pat;
      rgb     = colour;
   endtask

   // one frame up to the next vsync fall
   task automatic run_frame(input string name);
      int err0;
      int cnt0;
      err0 = pix_errors;
      cnt0 = pix_checked;
      @(negedge vsync);
      $display("test %s: %0d pixels, %0d errors", name, pix_checked - cnt0, pix_errors - err0);
   endtask

   // --------------------
   // raster geometry monitor
   // --------------------
   always @(posedge clk_36MHz)
   begin : track_raster
      if (reset)
      begin
         hs_run     <= 0;
         vs_run     <= 0;
         de_run     <= 0;
         de_lines   <= 0;
         hs_lines   <= 0;
         prev_hsync <= 1'b1;
         prev_vsync <= 1'b1;
         prev_de    <= 1'b0;
         frame_seen <= 1'b0;
      end
      else
      begin
         prev_hsync <= video.hsync;
         prev_vsync <= video.vsync;
         prev_de    <= video.de;
         // hsync width judged on its rising edge
         if (!video.hsync)
            hs_run <= hs_run + 1;
         else
         begin
            if (!prev_hsync)
            begin
               check_value("video.hsync low cycles", H_PULSE, hs_run, geom_errors);
               hs_lines <= hs_lines + 1;
            end
            hs_run <= 0;
         end
         // pixels per line and lines per frame
         if (video.de)
            de_run <= de_run + 1;
         else
         begin
            if (prev_de)
            begin
               check_value("video.de cycles per line", ACTIVE_H, de_run, geom_errors);
               de_lines <= de_lines + 1;
            end
            de_run <= 0;
         end
         if (!video.vsync)
            vs_run <= vs_run + 1;
         else
         begin
            if (!prev_vsync)
               check_value("video.vsync low cycles", V_PULSE * LINE_CYCLES, vs_run, geom_errors);
            vs_run <= 0;
         end
         // frame boundary on vsync fall
         if (prev_vsync && !video.vsync)
         begin
            if (frame_seen)
            begin
               check_value("video.de lines per frame", ACTIVE_V, de_lines, geom_errors);
               check_value("video.hsync pulses per frame", FRAME_LINES, hs_lines, geom_errors);
            end
            frame_seen <= 1'b1;
            de_lines   <= 0;
            hs_lines   <= 0;
         end
      end
   end

   // --------------------
   // pixel and coordinate compare
   // --------------------
   always @(posedge clk_36MHz)
   begin : compare_video
      pixel_t expected;
      if (!reset)
      begin
         if (video.de)
         begin
            expected = pattern_ref(pattern, rgb, de_run, de_lines);
            pix_checked++;
            check_value("video.pixel", {29'd0, expected}, {29'd0, video.pixel}, pix_errors);
            check_value("x", de_run, {22'd0, x}, coord_errors);
            check_value("y", de_lines, {22'd0, y}, coord_errors);
         end
         else
         begin
            // blanked outside the active area
            check_value("video.pixel", 0, {29'd0, video.pixel}, coord_errors);
            check_value("x", 0, {22'd0, x}, coord_errors);
            check_value("y", 0, {22'd0, y}, coord_errors);
         end
      end
   end

   // run limit
   always @(posedge clk_36MHz)
   begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout: video never completed all frames");
         $display("** FAIL **");
         $finish;
      end
   end

   // --------------------
   // stimulus
   // --------------------
   initial
   begin : stimulus
      void'($urandom(SEED));
      reset      = 1'b1;
      pattern    = PAT_BARS;
      rgb        = BLACK;
      // reset over three edges with outputs checked on the later two
      @(posedge clk_36MHz);
      repeat (2)
      begin
         @(posedge clk_36MHz);
         check_idle_outputs();
      end
      #10;
      reset = 1'b0;
      // last reset cycle and then the first cycle after it
      repeat (2)
      begin
         @(posedge clk_36MHz);
         check_idle_outputs();
      end
      $display("test reset state: %0d errors", reset_errors);

      // active lines of frame 0 follow the first vsync fall
      @(negedge vsync);
      run_frame("colour bars, first frame after reset");
      apply_setting(PAT_CHECKER, BLACK);
      run_frame("checkerboard");
      repeat (3)
      begin
         apply_setting(PAT_SOLID, pixel_t'(3'($urandom())));
         run_frame($sformatf("solid colour %0h", rgb));
      end
      apply_setting(PAT_BORDER, BLACK);
      run_frame("border");

      $display("test raster geometry: %0d errors", geom_errors);
      $display("test coordinates and blanking: %0d errors", coord_errors);
      $display("checks passed %0d, errors %0d", pass_count, error_count);
      if (error_count == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the VGA testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --timescale 1ns/10ps \
   --top-module vga_tb -f vga_top.f -Mdir obj_dir -o vga_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

output=$(./obj_dir/vga_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qxF '** PASS **'; then
   exit 0
fi
echo "pass line not found"
exit 1

// ==== source/line_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_buffer #(
   parameter int ACTIVE_H = 640
) (
   input  wire                  clk_36MHz,
   input  wire                  wr_en,
   input  wire                  wr_bank,
   input  wire [9:0]            wr_addr,
   input  wire vga_pkg::pixel_t wr_pixel,
   input  wire                  rd_bank,
   input  wire [9:0]            rd_addr,
   output vga_pkg::pixel_t      rd_pixel
);
   import vga_pkg::*;

   // two lines back to back
   localparam int DEPTH = 2 * ACTIVE_H;
   localparam int AW    = $clog2(DEPTH);

   pixel_t mem [0:DEPTH-1];

   logic [AW-1:0] wr_index;
   logic [AW-1:0] rd_index;

   // bank 1 sits one line above bank 0
   assign wr_index = wr_bank ? AW'(ACTIVE_H) + AW'(wr_addr) : AW'(wr_addr);
   assign rd_index = rd_bank ? AW'(ACTIVE_H) + AW'(rd_addr) : AW'(rd_addr);

   // producer side
   always_ff @(posedge clk_36MHz)
   begin
      if (wr_en)
         mem[wr_index] <= wr_pixel;
   end

   // --------------------
   // registered read, one cycle
   // --------------------
   always_ff @(posedge clk_36MHz)
   begin
      rd_pixel <= mem[rd_index];
   end

endmodule

`default_nettype wire

// ==== source/pattern_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module pattern_gen #(
   parameter int ACTIVE_H = 640,
   parameter int ACTIVE_V = 480
) (
   input  wire                     clk_36MHz,
   input  wire                     reset,
   input  wire vga_pkg::fill_req_t fill_req,
   input  wire vga_pkg::pattern_e  pattern,
   input  wire vga_pkg::pixel_t    rgb,
   output logic                    wr_en,
   output logic                    wr_bank,
   output logic [9:0]              wr_addr,
   output vga_pkg::pixel_t         wr_pixel
);
   import vga_pkg::*;

   // eight bars across the line
   localparam int BAR_W = ACTIVE_H / 8;

   localparam pixel_t WHITE = '{red: 1'b1, green: 1'b1, blue: 1'b1};
   localparam pixel_t BLACK = '{red: 1'b0, green: 1'b0, blue: 1'b0};

   // fill walker
   logic       busy;
   logic [9:0] pix_cnt;
   logic [9:0] bar_cnt;
   logic [2:0] bar_idx;

   // settings captured on the strobe
   pattern_e   pat_q;
   pixel_t     rgb_q;
   logic [9:0] line_q;
   logic       bank_q;

   logic       on_border;

   // --------------------
   // pixel walker
   // --------------------
   always_ff @(posedge clk_36MHz)
   begin
      if (reset)
      begin
         busy    <= 1'b0;
         pix_cnt <= '0;
         bar_cnt <= '0;
         bar_idx <= '0;
      end
      else if (fill_req.start)
      begin
         // a new strobe always restarts the line
         busy    <= 1'b1;
         pix_cnt <= '0;
         bar_cnt <= '0;
         bar_idx <= '0;
      end
      else if (busy)
      begin
         pix_cnt <= pix_cnt + 10'd1;
         // last pixel of the line
         if (pix_cnt == 10'(ACTIVE_H - 1))
            busy <= 1'b0;
         // bar index steps without a divider
         if (bar_cnt == 10'(BAR_W - 1))
         begin
            bar_cnt <= '0;
            bar_idx <= bar_idx + 3'd1;
         end
         else
            bar_cnt <= bar_cnt + 10'd1;
      end
   end

   // capture request and inputs
   always_ff @(posedge clk_36MHz)
   begin
      if (fill_req.start)
      begin
         pat_q  <= pattern;
         rgb_q  <= rgb;
         line_q <= fill_req.line;
         bank_q <= fill_req.bank;
      end
   end

   // --------------------
   // colour per pattern
   // --------------------
   assign on_border = (pix_cnt == 10'd0) || (pix_cnt == 10'(ACTIVE_H - 1)) ||
                      (line_q == 10'd0) || (line_q == 10'(ACTIVE_V - 1));

   always_comb
   begin
      case (pat_q)
         // 7 - index, white bar first
         PAT_BARS:    wr_pixel = pixel_t'(~bar_idx);
         PAT_CHECKER: wr_pixel = (pix_cnt[CHECKER_SHIFT] ^ line_q[CHECKER_SHIFT]) ? WHITE : BLACK;
         PAT_SOLID:   wr_pixel = rgb_q;
         PAT_BORDER:  wr_pixel = on_border ? WHITE : BLACK;
         default:     wr_pixel = BLACK;
      endcase
   end

   // write port straight from the walker
   assign wr_en   = busy;
   assign wr_bank = bank_q;
   assign wr_addr = pix_cnt;

endmodule

`default_nettype wire

// ==== source/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

   // --------------------
   // pixel and pattern types
   // --------------------

   // one bit per channel, red in the msb
   typedef struct packed {
      logic red;
      logic green;
      logic blue;
   } pixel_t;

   // test pattern opcode
   typedef enum logic [1:0] {
      PAT_BARS    = 2'd0,
      PAT_CHECKER = 2'd1,
      PAT_SOLID   = 2'd2,
      PAT_BORDER  = 2'd3
   } pattern_e;

   // --------------------
   // block to block bundles
   // --------------------

   // line render request, timing to producer
   typedef struct packed {
      logic [9:0] line;
      logic       bank;
      logic       start;
   } fill_req_t;

   // video port, syncs active low
   typedef struct packed {
      logic   hsync;
      logic   vsync;
      logic   de;
      pixel_t pixel;
   } video_out_t;

   // checker cells 8 pixels square
   localparam int CHECKER_SHIFT = 3;

endpackage

`default_nettype wire

// ==== source/vga_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_timing #(
   parameter int ACTIVE_H = 640,
   parameter int ACTIVE_V = 480,
   parameter int HFP      = 32,
   parameter int H_PULSE  = 48,
   parameter int HBP      = 112,
   parameter int VFP      = 1,
   parameter int V_PULSE  = 3,
   parameter int VBP      = 25
) (
   input  wire                  clk_36MHz,
   input  wire                  reset,
   output vga_pkg::fill_req_t   fill_req,
   output logic                 rd_bank,
   output logic [9:0]           rd_addr,
   input  wire vga_pkg::pixel_t rd_pixel,
   output vga_pkg::video_out_t  video,
   output logic [9:0]           x,
   output logic [9:0]           y
);
   import vga_pkg::*;

   // blanking sits at the front of line and frame
   localparam int BLACK_H  = HFP + H_PULSE + HBP;
   localparam int BLACK_V  = VFP + V_PULSE + VBP;
   localparam int H_PIXELS = BLACK_H + ACTIVE_H;
   localparam int V_LINES  = BLACK_V + ACTIVE_V;

   logic [9:0] h_counter;
   logic [9:0] v_counter;

   // raster decode
   logic       hsync_n;
   logic       vsync_n;
   logic       h_active;
   logic       v_active;
   logic       active;
   logic [9:0] line_idx;
   logic [9:0] next_line;
   logic [9:0] next_idx;
   logic       next_active;

   // output stage
   logic       hsync_q;
   logic       vsync_q;
   logic       de_q;

   // --------------------
   // raster counters
   // --------------------
   always_ff @(posedge clk_36MHz)
   begin
      if (reset)
      begin
         h_counter <= '0;
         v_counter <= '0;
      end
      else if (h_counter < 10'(H_PIXELS - 1))
         h_counter <= h_counter + 10'd1;
      else
      begin
         // end of line, step or wrap the frame
         h_counter <= '0;
         if (v_counter < 10'(V_LINES - 1))
            v_counter <= v_counter + 10'd1;
         else
            v_counter <= '0;
      end
   end

   // front porch, pulse, back porch
   assign hsync_n  = !(h_counter >= 10'(HFP) && h_counter < 10'(HFP + H_PULSE));
   assign vsync_n  = !(v_counter >= 10'(VFP) && v_counter < 10'(VFP + V_PULSE));
   assign h_active = (h_counter >= 10'(BLACK_H));
   assign v_active = (v_counter >= 10'(BLACK_V));
   assign active   = h_active && v_active;
   assign line_idx = v_counter - 10'(BLACK_V);

   // --------------------
   // fill one line ahead
   // --------------------
   assign next_line   = (v_counter == 10'(V_LINES - 1)) ? 10'd0 : v_counter + 10'd1;
   assign next_active = (next_line >= 10'(BLACK_V));
   assign next_idx    = next_line - 10'(BLACK_V);

   always_ff @(posedge clk_36MHz)
   begin
      if (reset)
         fill_req <= '0;
      else
      begin
         // strobe at line start
         fill_req.start <= (h_counter == 10'd0) && next_active;
         fill_req.line  <= next_idx;
         fill_req.bank  <= next_idx[0];
      end
   end

   // reader takes the bank of the line on screen
   assign rd_bank = line_idx[0];
   assign rd_addr = h_active ? h_counter - 10'(BLACK_H) : 10'd0;

   // --------------------
   // video output, one cycle behind counters
   // --------------------
   always_ff @(posedge clk_36MHz)
   begin
      if (reset)
      begin
         hsync_q <= 1'b1;
         vsync_q <= 1'b1;
         de_q    <= 1'b0;
         x       <= '0;
         y       <= '0;
      end
      else
      begin
         hsync_q <= hsync_n;
         vsync_q <= vsync_n;
         de_q    <= active;
         // coordinates zero outside the active area
         x       <= active ? h_counter - 10'(BLACK_H) : 10'd0;
         y       <= active ? line_idx : 10'd0;
      end
   end

   // colour is the buffer read register, blanked by delayed de
   assign video = '{hsync: hsync_q,
                    vsync: vsync_q,
                    de:    de_q,
                    pixel: de_q ? rd_pixel : pixel_t'(3'b000)};

endmodule

`default_nettype wire

// ==== source/vga_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_top #(
   parameter int ACTIVE_H = 640,
   parameter int ACTIVE_V = 480,
   parameter int HFP      = 32,
   parameter int H_PULSE  = 48,
   parameter int HBP      = 112,
   parameter int VFP      = 1,
   parameter int V_PULSE  = 3,
   parameter int VBP      = 25
) (
   input  wire                    clk_36MHz,
   input  wire                    reset,
   input  wire vga_pkg::pattern_e pattern,
   input  wire vga_pkg::pixel_t   rgb,
   output vga_pkg::video_out_t    video,
   output logic [9:0]             x,
   output logic [9:0]             y
);
   import vga_pkg::*;

   // timing to producer
   fill_req_t  fill_req;

   // producer to buffer
   logic       wr_en;
   logic       wr_bank;
   logic [9:0] wr_addr;
   pixel_t     wr_pixel;

   // buffer to timing
   logic       rd_bank;
   logic [9:0] rd_addr;
   pixel_t     rd_pixel;

   // --------------------
   // line producer
   // --------------------
   pattern_gen #(
      .ACTIVE_H (ACTIVE_H),
      .ACTIVE_V (ACTIVE_V)
   ) i_pattern_gen (
      .clk_36MHz (clk_36MHz),
      .reset     (reset),
      .fill_req  (fill_req),
      .pattern   (pattern),
      .rgb       (rgb),
      .wr_en     (wr_en),
      .wr_bank   (wr_bank),
      .wr_addr   (wr_addr),
      .wr_pixel  (wr_pixel)
   );

   // ping-pong line store
   line_buffer #(
      .ACTIVE_H (ACTIVE_H)
   ) i_line_buffer (
      .clk_36MHz (clk_36MHz),
      .wr_en     (wr_en),
      .wr_bank   (wr_bank),
      .wr_addr   (wr_addr),
      .wr_pixel  (wr_pixel),
      .rd_bank   (rd_bank),
      .rd_addr   (rd_addr),
      .rd_pixel  (rd_pixel)
   );

   // --------------------
   // raster timing and output
   // --------------------
   vga_timing #(
      .ACTIVE_H (ACTIVE_H),
      .ACTIVE_V (ACTIVE_V),
      .HFP      (HFP),
      .H_PULSE  (H_PULSE),
      .HBP      (HBP),
      .VFP      (VFP),
      .V_PULSE  (V_PULSE),
      .VBP      (VBP)
   ) i_vga_timing (
      .clk_36MHz (clk_36MHz),
      .reset     (reset),
      .fill_req  (fill_req),
      .rd_bank   (rd_bank),
      .rd_addr   (rd_addr),
      .rd_pixel  (rd_pixel),
      .video     (video),
      .x         (x),
      .y         (y)
   );

endmodule

`default_nettype wire

// ==== vga_top.f ====
source/vga_pkg.sv
source/pattern_gen.sv
source/line_buffer.sv
source/vga_timing.sv
source/vga_top.sv
bench/vga_tb.sv
